//--- src/bus_pkg.sv
package bus_pkg;

	// every address and data word on the peripheral bus is this wide.
	localparam int word_width = 32;

	// each device sits at the base of its own megabyte region in the high
	// address range and answers to that one full address only.
	// the decoder compares all 32 bits, so the rest of each region reads zero.

	// read-only switch inputs.
	localparam logic [word_width-1:0] switches_addr = 32'hf010_0000;

	// led output register.
	localparam logic [word_width-1:0] leds_addr = 32'hf020_0000;

	// free-running cycle timer.
	localparam logic [word_width-1:0] timer_addr = 32'hf060_0000;

	// seven-segment display register, one byte per digit.
	localparam logic [word_width-1:0] sseg_addr = 32'hf0a0_0000;

	// one select line per mapped register.
	// the switch and led registers share a device but get separate selects.
	localparam int dev_sel_width = 4;

	// the select vector in the decoder packs the lines in this order.
	// bit 0 is the display, then leds, then switches, then the timer.
	// the order only matters for the one-hot check and the read mux.
	// keep it in step with bus_decoder when a device is added.

	// there is no wait state and no error response on this bus.
	// a read of a hole in the map simply returns zero.
	// a write to a hole is dropped without any side effect.

endpackage

//--- src/display_pkg.sv
package display_pkg;

	// the board oscillator drives clk directly.
	localparam int clock_freq = 25_000_000;

	// four digits refreshed at 60 Hz gives 240 digit slots per second.
	localparam int scan_ticks = clock_freq / 240;

	// width of the scan counter that counts up to scan_ticks.
	localparam int scan_cnt_width = $clog2(scan_ticks);

	// the display has four digits of eight segment lines each.
	localparam int digit_count = 4;
	localparam int digit_width = 8;

	// anode patterns are active low, one low bit per digit.
	localparam logic [digit_count-1:0] an_digit0 = 4'b1110;
	localparam logic [digit_count-1:0] an_digit1 = 4'b1101;
	localparam logic [digit_count-1:0] an_digit2 = 4'b1011;
	localparam logic [digit_count-1:0] an_digit3 = 4'b0111;

	// the display register is written over the bus as one word.
	// the scan logic reads the same bits back as one byte per digit.
	// digit 0 is the low byte and each next digit takes the next byte up.
	typedef union packed {
		logic [digit_count*digit_width-1:0] word;	// bus view.
		logic [digit_count-1:0][digit_width-1:0] digit;	// scan view.
	} sseg_word_u;

	// the segment byte goes to the pins unchanged.
	// its polarity and segment order are up to whatever software writes it.

	// a full refresh of all four digits takes four scan periods.
	// that is digit_count times scan_ticks cycles of clk.

	// the anode leaves reset on digit 0.
	// reset also clears the scan counter, so the first step is a full period away.

endpackage

//--- src/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import bus_pkg::*; (
	input  logic                  de,		// data bus enable from the cpu side.
	input  logic [word_width-1:0] daddr,		// full data address.
	input  logic [word_width-1:0] sseg_rdata,	// display register readback.
	input  logic [word_width-1:0] leds_rdata,	// led register readback.
	input  logic [word_width-1:0] sw_rdata,	// synchronized switch value.
	input  logic [word_width-1:0] timer_rdata,	// current timer count.
	output logic                  sseg_sel,
	output logic                  gpio_leds_sel,
	output logic                  gpio_sw_sel,
	output logic                  timer_sel,
	output logic [word_width-1:0] dout		// read data back to the cpu.
);

	// the select lines gathered in one vector for the checks below.
	logic [dev_sel_width-1:0] sel_vec;

	// each select is the enable qualified by an exact address match.
	// with de low every select stays low, so nothing is written or read.
	assign sseg_sel      = de && (daddr == sseg_addr);
	assign gpio_leds_sel = de && (daddr == leds_addr);
	assign gpio_sw_sel   = de && (daddr == switches_addr);
	assign timer_sel     = de && (daddr == timer_addr);

	assign sel_vec = {timer_sel, gpio_sw_sel, gpio_leds_sel, sseg_sel};

	// read data multiplexer.
	// the devices always present their words and the mux picks one.
	// an unmapped address or a bus with de low reads as zero.
	// the mux ignores drw, so dout also shows the addressed word during a write.
	// the cpu side only samples dout on reads.
	always_comb begin
		dout = '0;
		if (sseg_sel) begin
			dout = sseg_rdata;
		end else if (gpio_leds_sel) begin
			dout = leds_rdata;
		end else if (gpio_sw_sel) begin
			dout = sw_rdata;
		end else if (timer_sel) begin
			dout = timer_rdata;
		end
	end

	// the address map must keep the devices apart.
	// two overlapping entries in bus_pkg would raise two selects here.
	// the priority chain above would then hide one device without a trace.
	always_comb begin
		assert ($onehot0(sel_vec))
			else $error("bus_decoder: more than one device selected at %h", daddr);
	end

	// the decoder holds no state of its own.
	// writes reach a device through its select together with drw in the device.
	// reads complete in the same cycle, so there is no wait state on this bus.
	// a device that needs more time would need a handshake, which this bus lacks.
	// the select names follow the device ports they drive in periph_top.
	// the switch select only steers the read mux.
	// it is still an output, so every mapped register shows up at the top.

endmodule

//--- src/mod_sseg.sv
`timescale 1ns/1ps

module mod_sseg import bus_pkg::*, display_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  sel,			// register selected by the decoder.
	input  logic                  drw,			// high for a write.
	input  logic [word_width-1:0] din,
	output logic [word_width-1:0] rdata,
	output logic [digit_count-1:0] sseg_an,		// active-low digit anodes.
	output logic [digit_width-1:0] sseg_display	// segments of the lit digit.
);

	sseg_word_u                sseg_reg;	// the display word holds one byte per digit.
	logic [scan_cnt_width-1:0] scan_cnt;	// cycles spent on the current digit.
	logic [digit_count-1:0]    an_next;	// anode pattern for the next digit.

	// the register is written as a whole bus word.
	always_ff @(posedge clk) begin
		if (rst) begin
			sseg_reg.word <= '0;
		end else if (sel && drw) begin
			sseg_reg.word <= din;
		end
	end

	assign rdata = sseg_reg.word;	// readback is the word as written.

	// the anodes step through the digits from low byte to high byte.
	always_comb begin
		case (sseg_an)
			an_digit0: an_next = an_digit1;
			an_digit1: an_next = an_digit2;
			an_digit2: an_next = an_digit3;
			default:   an_next = an_digit0;	// also recovers a corrupt pattern.
		endcase
	end

	// the scan counter holds each digit for scan_ticks cycles.
	always_ff @(posedge clk) begin
		if (rst) begin
			scan_cnt <= '0;
			sseg_an  <= an_digit0;
		end else if (scan_cnt == scan_cnt_width'(scan_ticks - 1)) begin
			scan_cnt <= '0;
			sseg_an  <= an_next;	// move on to the next digit.
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// the digit multiplexer reads the register through its byte view.
	// it is combinational, so a write shows up on the pins one cycle later.
	always_comb begin
		case (sseg_an)
			an_digit1: sseg_display = sseg_reg.digit[1];
			an_digit2: sseg_display = sseg_reg.digit[2];
			an_digit3: sseg_display = sseg_reg.digit[3];
			default:   sseg_display = sseg_reg.digit[0];
		endcase
	end

	// exactly one digit is lit at any time outside of reset.
	// this holds across every step of the scan, not only just after reset.
	assert property (@(posedge clk) disable iff (rst) $onehot(~sseg_an))
		else $error("mod_sseg: anode pattern %b is not a single digit", sseg_an);

endmodule

//--- src/mod_gpio.sv
`timescale 1ns/1ps

module mod_gpio import bus_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  leds_sel,	// led register selected.
	input  logic                  drw,		// high for a write.
	input  logic [word_width-1:0] din,
	input  logic [7:0]            switches,	// asynchronous board inputs.
	output logic [7:0]            leds,
	output logic [word_width-1:0] leds_rdata,
	output logic [word_width-1:0] sw_rdata
);

	logic [7:0] sw_meta;	// the first synchronizer stage may go metastable.
	logic [7:0] sw_sync;	// the second stage is safe to use in the clk domain.

	// the led register keeps only the low byte of the bus word.
	always_ff @(posedge clk) begin
		if (rst) begin
			leds <= '0;
		end else if (leds_sel && drw) begin
			leds <= din[7:0];
		end
	end

	// two flip-flops bring the switches into the clock domain.
	// a change on the pins is readable after the second edge.
	always_ff @(posedge clk) begin
		if (rst) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= switches;
			sw_sync <= sw_meta;
		end
	end

	// both registers read back as zero-extended words.
	assign leds_rdata = {{(word_width - 8){1'b0}}, leds};
	assign sw_rdata   = {{(word_width - 8){1'b0}}, sw_sync};	// read-only.

	// the switch word is always presented.
	// the decoder alone decides when it reaches dout.

endmodule

//--- src/mod_timer.sv
`timescale 1ns/1ps

module mod_timer import bus_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  sel,		// timer selected by the decoder.
	input  logic                  drw,		// high for a write.
	input  logic [word_width-1:0] din,
	output logic [word_width-1:0] rdata	// current count.
);

	logic [word_width-1:0] count;	// free-running cycle count.

	// the counter adds one on every edge.
	// a write loads din in place of the increment for that one edge.
	// the count then runs on from the loaded value.
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (sel && drw) begin
			count <= din;
		end else begin
			count <= count + 1'b1;	// wraps to zero after all ones.
		end
	end

	// a read returns the count as it stands in that cycle.
	// there is no latch on read, so two reads a cycle apart differ by one.
	assign rdata = count;

	// software measures a span by subtracting two reads.
	// the wrap takes about three minutes at the board clock.
	// loading zero restarts a measurement at a known point.

endmodule

//--- src/periph_top.sv
`timescale 1ns/1ps

module periph_top import bus_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,			// synchronous, active high.
	input  logic                  de,			// data bus enable.
	input  logic                  drw,			// high for a write, low for a read.
	input  logic [word_width-1:0] daddr,
	input  logic [word_width-1:0] din,
	input  logic [7:0]            switches,
	output logic [word_width-1:0] dout,
	output logic [7:0]            leds,
	output logic [3:0]            sseg_an,
	output logic [7:0]            sseg_display
);

	// per-register selects from the decoder.
	logic sseg_sel;
	logic gpio_leds_sel;
	logic gpio_sw_sel;
	logic timer_sel;

	// read words returned by the devices.
	logic [word_width-1:0] sseg_rdata;
	logic [word_width-1:0] leds_rdata;
	logic [word_width-1:0] sw_rdata;
	logic [word_width-1:0] timer_rdata;

	// the decoder turns the address into selects and muxes the read data.
	bus_decoder decoder_i (
		.de            (de),
		.daddr         (daddr),
		.sseg_rdata    (sseg_rdata),
		.leds_rdata    (leds_rdata),
		.sw_rdata      (sw_rdata),
		.timer_rdata   (timer_rdata),
		.sseg_sel      (sseg_sel),
		.gpio_leds_sel (gpio_leds_sel),
		.gpio_sw_sel   (gpio_sw_sel),
		.timer_sel     (timer_sel),
		.dout          (dout)
	);

	// the devices never see the address, only their own select.
	mod_sseg sseg_i (
		.clk          (clk),
		.rst          (rst),
		.sel          (sseg_sel),
		.drw          (drw),
		.din          (din),
		.rdata        (sseg_rdata),
		.sseg_an      (sseg_an),
		.sseg_display (sseg_display)
	);

	// the switch select only steers the read mux, so gpio does not take it.
	mod_gpio gpio_i (
		.clk        (clk),
		.rst        (rst),
		.leds_sel   (gpio_leds_sel),
		.drw        (drw),
		.din        (din),
		.switches   (switches),
		.leds       (leds),
		.leds_rdata (leds_rdata),
		.sw_rdata   (sw_rdata)
	);

	mod_timer timer_i (
		.clk   (clk),
		.rst   (rst),
		.sel   (timer_sel),
		.drw   (drw),
		.din   (din),
		.rdata (timer_rdata)
	);

	// a stray switch select must never come with a write.
	// the switch register is read-only, so such a write is a software bug.
	assert property (@(posedge clk) disable iff (rst)
		gpio_sw_sel |-> !drw)
		else $warning("periph_top: write to the read-only switch register");

endmodule

//--- verification/periph_checker.sv
`timescale 1ns/1ps

module periph_checker import bus_pkg::*, display_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  de,
	input  logic                  drw,
	input  logic [word_width-1:0] daddr,
	input  logic [word_width-1:0] din,
	input  logic [7:0]            switches,
	input  logic [word_width-1:0] dout,
	input  logic [7:0]            leds,
	input  logic [3:0]            sseg_an,
	input  logic [7:0]            sseg_display,
	input  logic                  exp_check,	// the stimulus table holds a value for this read.
	input  logic [word_width-1:0] exp_value,
	output int                    error_count
);

	logic [word_width-1:0] m_sseg;	// model of the display register.
	logic [7:0]            m_leds;	// model of the led register.
	logic [word_width-1:0] m_timer;	// model of the cycle count.
	logic [7:0]            m_sw_1;	// first switch stage.
	logic [7:0]            m_sw_2;	// second switch stage, the readable one.
	logic [3:0]            m_an;	// anode pattern the display should show.
	int                    m_scan;	// cycles spent on the current digit.
	int                    errors = 0;

	assign error_count = errors;

	// the segment byte that belongs to an active-low anode pattern.
	function automatic logic [7:0] lit_byte(input logic [3:0] an, input logic [31:0] word);
		case (an)
			an_digit1: return word[15:8];
			an_digit2: return word[23:16];
			an_digit3: return word[31:24];
			default:   return word[7:0];
		endcase
	endfunction

	// the scan runs from the low digit to the high one and wraps.
	function automatic logic [3:0] next_anode(input logic [3:0] an);
		case (an)
			an_digit0: return an_digit1;
			an_digit1: return an_digit2;
			an_digit2: return an_digit3;
			default:   return an_digit0;
		endcase
	endfunction

	// what a read of this address should return; holes in the map read zero.
	function automatic logic [31:0] model_read(input logic [31:0] addr);
		case (addr)
			sseg_addr:     return m_sseg;
			leds_addr:     return {24'h0, m_leds};
			switches_addr: return {24'h0, m_sw_2};
			timer_addr:    return m_timer;
			default:       return 32'h0;
		endcase
	endfunction

	task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] want);
		errors++;
		$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
	endtask

	// outputs are compared against the model as it stood before this edge.
	always @(posedge clk) begin
		if (!rst) begin
			if (leds !== m_leds) mismatch("leds", {24'h0, leds}, {24'h0, m_leds});
			if (sseg_an !== m_an) mismatch("sseg_an", {28'h0, sseg_an}, {28'h0, m_an});
			if (sseg_display !== lit_byte(m_an, m_sseg)) begin
				mismatch("sseg_display", {24'h0, sseg_display}, {24'h0, lit_byte(m_an, m_sseg)});
			end
			if (!de && dout !== 32'h0) mismatch("dout with de low", dout, 32'h0);
			if (de && !drw && dout !== model_read(daddr)) begin
				mismatch($sformatf("read of %h", daddr), dout, model_read(daddr));
			end
			if (exp_check && dout !== exp_value) mismatch("table read", dout, exp_value);
		end
	end

	// the model takes writes at the same edge as the registers do.
	always @(posedge clk) begin
		if (rst) begin
			m_sseg  <= '0;
			m_leds  <= '0;
			m_timer <= '0;
			m_sw_1  <= '0;
			m_sw_2  <= '0;
			m_an    <= an_digit0;
			m_scan  <= 0;
		end else begin
			if (de && drw && daddr == sseg_addr) m_sseg <= din;
			if (de && drw && daddr == leds_addr) m_leds <= din[7:0];
			m_timer <= (de && drw && daddr == timer_addr) ? din : m_timer + 32'd1;
			m_sw_1  <= switches;
			m_sw_2  <= m_sw_1;	// readable two edges after the pins change.
			if (m_scan == scan_ticks - 1) begin
				m_scan <= 0;
				m_an   <= next_anode(m_an);
			end else begin
				m_scan <= m_scan + 1;
			end
		end
	end

endmodule

//--- verification/periph_tb.sv
`timescale 1ns/1ps

module periph_tb import bus_pkg::*, display_pkg::*; ();

	localparam int cycle_limit = 1000;		// longest plain wait in the table.
	localparam int an_limit    = 2 * scan_ticks;	// one digit step must come sooner.

	typedef enum logic [2:0] {op_write, op_read, op_switch, op_wait, op_wait_an} op_e;

	typedef struct packed {
		op_e         op;
		logic [31:0] addr;
		logic [31:0] data;	// write data, switch value, cycle count or anode.
		logic [31:0] expected;
		logic        check;	// compare the read with expected.
	} step_t;

	logic        clk;
	logic        rst;
	logic        de;
	logic        drw;
	logic [31:0] daddr;
	logic [31:0] din;
	logic [7:0]  switches;
	logic [31:0] dout;
	logic [7:0]  leds;
	logic [3:0]  sseg_an;
	logic [7:0]  sseg_display;
	logic        exp_check;
	logic [31:0] exp_value;
	int          error_count;
	int          timeouts = 0;
	logic [31:0] lfsr_state = 32'hf08c_342b;
	step_t       steps[$];

	periph_top dut_i (.*);

	periph_checker checker_i (.*);

	// 100 ns period, rising edges at 50, 150 and so on.
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// fibonacci lfsr for x^32 + x^22 + x^2 + x + 1, one step per bit taken.
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	task automatic add_step(input op_e op, input logic [31:0] addr, input logic [31:0] data,
			input logic [31:0] expected, input logic check);
		step_t s;
		s.op = op;
		s.addr = addr;
		s.data = data;
		s.expected = expected;
		s.check = check;
		steps.push_back(s);
	endtask

	task automatic build_table();
		logic [31:0] disp;
		logic [31:0] led;
		logic [31:0] sw;
		logic [31:0] t0;
		logic [31:0] t1;
		add_step(op_read, sseg_addr, 0, 0, 1'b1);	// everything starts cleared.
		add_step(op_read, leds_addr, 0, 0, 1'b1);
		add_step(op_read, switches_addr, 0, 0, 1'b1);
		add_step(op_read, timer_addr, 0, 0, 1'b0);	// counting since reset, model only.
		disp = lfsr_take(32);
		add_step(op_write, sseg_addr, disp, 0, 1'b0);
		add_step(op_read, sseg_addr, 0, disp, 1'b1);
		add_step(op_wait_an, 0, {28'h0, an_digit1}, 0, 1'b0);	// one full turn of the scan.
		add_step(op_wait_an, 0, {28'h0, an_digit2}, 0, 1'b0);
		add_step(op_wait_an, 0, {28'h0, an_digit3}, 0, 1'b0);
		add_step(op_wait_an, 0, {28'h0, an_digit0}, 0, 1'b0);
		led = lfsr_take(32);
		add_step(op_write, leds_addr, led, 0, 1'b0);
		add_step(op_read, leds_addr, 0, {24'h0, led[7:0]}, 1'b1);
		for (int k = 0; k < 2; k++) begin
			sw = lfsr_take(8);
			add_step(op_switch, 0, sw, 0, 1'b0);
			add_step(op_wait, 0, 3, 0, 1'b0);
			add_step(op_read, switches_addr, 0, sw, 1'b1);
		end
		t0 = lfsr_take(32);
		add_step(op_write, timer_addr, t0, 0, 1'b0);
		add_step(op_read, timer_addr, 0, t0, 1'b1);	// the loaded value, one cycle on.
		t1 = lfsr_take(32);
		add_step(op_write, timer_addr, t1, 0, 1'b0);
		add_step(op_wait, 0, 7, 0, 1'b0);
		add_step(op_read, timer_addr, 0, t1 + 32'd7, 1'b1);
		add_step(op_read, 32'hf030_0000, 0, 0, 1'b1);	// holes in the map read zero.
		add_step(op_read, sseg_addr + 32'd4, 0, 0, 1'b1);
		add_step(op_write, 32'hf030_0000, lfsr_take(32), 0, 1'b0);
		add_step(op_write, 32'h0000_0000, lfsr_take(32), 0, 1'b0);
		add_step(op_read, sseg_addr, 0, disp, 1'b1);	// untouched by the stray writes.
		add_step(op_read, leds_addr, 0, {24'h0, led[7:0]}, 1'b1);
	endtask

	task automatic wait_cycles(input int count);
		int c;
		c = 0;
		while (c < count && c < cycle_limit) begin
			@(negedge clk);
			c++;
		end
		if (c < count) begin
			$display("timeout: a wait of %0d cycles was cut short at %0d", count, c);
			timeouts++;
		end
	endtask

	// sseg_an is sampled at the falling edge, well away from the scan step.
	task automatic wait_anode(input logic [3:0] pattern);
		int c;
		c = 0;
		while (sseg_an !== pattern && c < an_limit) begin
			@(negedge clk);
			c++;
		end
		if (sseg_an !== pattern) begin
			$display("timeout: the anodes never reached pattern %b", pattern);
			timeouts++;
		end
	endtask

	task automatic apply_step(input step_t s);
		case (s.op)
			op_write: begin
				de = 1'b1;
				drw = 1'b1;
				daddr = s.addr;
				din = s.data;
				@(negedge clk);
			end
			op_read: begin
				de = 1'b1;
				daddr = s.addr;
				exp_check = s.check;
				exp_value = s.expected;
				@(negedge clk);
			end
			op_switch: begin
				switches = s.data[7:0];
				@(negedge clk);
			end
			op_wait:    wait_cycles(s.data);
			default:    wait_anode(s.data[3:0]);
		endcase
		de = 1'b0;	// back to an idle bus between rows.
		drw = 1'b0;
		daddr = '0;
		din = '0;
		exp_check = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		de = 1'b0;
		drw = 1'b0;
		daddr = '0;
		din = '0;
		switches = '0;
		exp_check = 1'b0;
		exp_value = '0;
		build_table();
		for (int c = 0; c < 5; c++) begin
			@(negedge clk);
		end
		rst = 1'b0;
		foreach (steps[i]) begin
			apply_step(steps[i]);
		end
		wait_cycles(2);	// let the checker see the last row.
		$display("checks done: %0d value errors, %0d timeouts", error_count, timeouts);
		if (error_count == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- project.f
src/bus_pkg.sv
src/display_pkg.sv
src/bus_decoder.sv
src/mod_sseg.sv
src/mod_gpio.sv
src/mod_timer.sv
src/periph_top.sv
verification/periph_checker.sv
verification/periph_tb.sv

//--- Makefile
TOP := periph_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f src/*.sv verification/*.sv
	verilator --binary --timing --assert -sv --top-module $(TOP) -f project.f

run: compile
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi; \
	if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
